/* project.f */
hw/cart_pkg.sv
hw/cpu_clock_enable.sv
hw/header_capture.sv
hw/mbc_regs.sv
hw/bank_mapper.sv
hw/mem_port.sv
hw/cart_top.sv
verif/cart_chk.sv
verif/cart_monitor.sv
verif/tb_cart.sv

/* Makefile */
# Verilator build and run for the cartridge testbench

SIM      = verilator
TOP      = tb_cart
FILELIST = project.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/tb_cart.sv */
// cartridge testbench
// downloads one image per mapper kind, then runs random cpu bus traffic
`timescale 1ns/1ps
`default_nettype none

module tb_cart;

	localparam int img_words  = 'h148 / 2 + 4;   // just past the size word
	localparam int ops        = 200;              // cpu accesses per mapper
	localparam int total_ops  = 5 * (img_words + ops);

	logic        clk_sys, reset;
	logic        dl_active, dl_wr, dl_wait;
	logic [24:0] dl_addr;
	logic [15:0] dl_data;
	logic        ce_cpu;
	logic [15:0] cpu_addr;
	logic        cpu_rd, cpu_wr;
	logic [7:0]  cpu_di, cpu_do;
	logic [23:0] mem_addr;
	logic [15:0] mem_din, mem_dout;
	logic [1:0]  mem_ds;
	logic        mem_we, mem_oe, cart_ready;

	logic [31:0] lfsr = 32'h6ed6_22cd;
	logic [15:0] mem [0:(1<<21)-1];   // 9 bank bits + 12 offset bits
	int          errs;

	cart_top dut (.*);

	cart_monitor mon (.*);

	// --------------------
	// memory model
	initial begin
		for (int i = 0; i < (1 << 21); i++)
			mem[i] = 16'(i) ^ 16'(i >> 8) ^ 16'ha5c3;   // whole address in the pattern
	end

	assign mem_dout = mem[mem_addr[20:0]];

	always @(posedge clk_sys) begin
		if (mem_we) begin
			if (mem_ds[0]) mem[mem_addr[20:0]][7:0] <= mem_din[7:0];
			if (mem_ds[1]) mem[mem_addr[20:0]][15:8] <= mem_din[15:8];
		end
	end

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// drive on the edge of a ce pulse, so inputs move in the cycle after it
	task automatic cpu_op(input logic rd, input logic wr, input logic [15:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		while (!ce_cpu) @(posedge clk_sys);
		cpu_rd   <= rd;
		cpu_wr   <= wr;
		cpu_addr <= a;
		cpu_di   <= d;
	endtask

	task automatic download(input logic [7:0] typ, input logic [7:0] rom_code,
	                        input logic [7:0] ram_code);
		logic [31:0] r;
		@(posedge clk_sys);
		dl_active <= 1'b1;
		for (int i = 0; i < img_words; i++) begin
			r = rand_bits(16);
			@(posedge clk_sys);
			dl_addr <= 25'(2 * i);
			if (i == 'h146 / 2)
				dl_data <= {typ, r[7:0]};
			else if (i == 'h148 / 2)
				dl_data <= {ram_code, rom_code};
			else
				dl_data <= r[15:0];
			dl_wr <= 1'b1;
			@(posedge clk_sys);
			dl_wr <= 1'b0;
			@(posedge clk_sys);
			while (dl_wait) @(posedge clk_sys);   // host waits out the write
		end
		@(posedge clk_sys);
		dl_active <= 1'b0;
	endtask

	// --------------------
	// one mapper: image, then a random mix of register writes and accesses
	task automatic run_mapper(input logic [7:0] typ);
		logic [31:0] r, kind, a, d;
		logic [7:0]  rom_code;
		r = rand_bits(4);
		if (r < 7) rom_code = 8'(r);
		else if (r < 11) rom_code = 8'h52;
		else if (r < 14) rom_code = 8'h53;
		else rom_code = 8'h07;   // unlisted code
		d = rand_bits(2);
		download(typ, rom_code, 8'(d));
		for (int k = 0; k < ops; k++) begin
			kind = rand_bits(3);
			a = rand_bits(16);
			d = rand_bits(8);
			case (kind[2:0])
				3'd0: cpu_op(0, 1, {3'd0, a[12:0]}, a[13] ? 8'h0a : 8'(d));   // mostly the key
				3'd1: cpu_op(0, 1, {3'd1, a[12:0]}, 8'(d));
				3'd2: cpu_op(0, 1, {3'd2, a[12:0]}, 8'(d));
				3'd3: cpu_op(0, 1, {3'd3, a[12:0]}, 8'(d));
				3'd4, 3'd5: cpu_op(1, 0, {1'b0, a[14:0]}, 8'h00);
				3'd6: cpu_op(1, 0, a[13] ? {7'b1010000, a[8:0]} : {3'd5, a[12:0]}, 8'h00);
				default: cpu_op(0, 1, {3'd5, a[12:0]}, 8'(d));
			endcase
		end
		cpu_op(0, 0, 16'h0000, 8'h00);   // lets the last write land
	endtask

	// --------------------
	initial begin
		reset = 1'b1;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		cpu_addr = '0;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		cpu_di = '0;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (20) @(posedge clk_sys);
		run_mapper(8'h00);   // plain 32 KB
		run_mapper(8'h03);
		run_mapper(8'h06);
		run_mapper(8'h13);
		run_mapper(8'h1b);
		repeat (20) @(posedge clk_sys);
		errs = mon.errors + dut.u_chk.fails;
		$display("checks %0d, mismatches %0d, assertion failures %0d",
		         mon.checks, mon.errors, dut.u_chk.fails);
		if (errs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// watchdog
	initial begin
		repeat (total_ops * 40 + 2000) @(posedge clk_sys);
		$display("timeout: the test sequence did not finish in time");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/cart_monitor.sv */
// cartridge monitor
// reference model of header decode and MBC state, compares every DUT response
`timescale 1ns/1ps
`default_nettype none

module cart_monitor
	import cart_pkg::*;
(
	input wire                   clk_sys,
	input wire                   reset,
	input wire                   dl_active,
	input wire                   dl_wr,
	input wire [mem_addr_w:0]    dl_addr,
	input wire [15:0]            dl_data,
	input wire                   dl_wait,
	input wire                   ce_cpu,
	input wire [cpu_addr_w-1:0]  cpu_addr,
	input wire                   cpu_rd,
	input wire                   cpu_wr,
	input wire [7:0]             cpu_di,
	input wire [7:0]             cpu_do,
	input wire [mem_addr_w-1:0]  mem_addr,
	input wire [15:0]            mem_din,
	input wire [1:0]             mem_ds,
	input wire                   mem_we,
	input wire                   mem_oe,
	input wire [15:0]            mem_dout,
	input wire                   cart_ready
);

	int checks = 0;
	int errors = 0;

	logic [7:0] m_type, m_rom, m_ram;   // captured header bytes
	logic [6:0] m_rom_bank;
	logic [1:0] m_ram_bank;
	logic       m_mode, m_rtc, m_ram_en;
	logic       seen_ce, busy, prev_wait, m_ready;
	int         lat, we_cnt;
	logic [23:0] exp_dl_addr;
	logic [15:0] exp_dl_data;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic fail(input string msg);
		errors++;
		$display("error at %0t: %s", $time, msg);
	endtask

	// --------------------
	// header rules
	function automatic mapper_t mapper_of(input logic [7:0] t);
		if (t >= 8'd1 && t <= 8'd3) return mapper_mbc1;
		if (t == 8'd5 || t == 8'd6) return mapper_mbc2;
		if (t >= 8'd15 && t <= 8'd19) return mapper_mbc3;
		if (t >= 8'd25 && t <= 8'd30) return mapper_mbc5;
		return mapper_none;
	endfunction

	function automatic logic [6:0] rom_mask_of(input logic [7:0] c);
		logic [7:0] m;
		if (c <= 8'd6) m = (8'd2 << c) - 8'd1;   // n+1 ones
		else if (c == 8'h52) m = 8'h47;
		else if (c == 8'h53) m = 8'h4f;
		else m = 8'h5f;
		return m[6:0];
	endfunction

	// expected bank field for a cpu address
	function automatic logic [8:0] exp_bank(input logic [15:0] a);
		mapper_t    mp;
		logic [6:0] rb;
		logic [1:0] rm;
		mp = mapper_of(m_type);
		if (mp == mapper_none) return {7'd0, a[14:13]};   // linear 32 KB
		if (!a[15]) begin
			if (!a[14]) return {8'd0, a[13]};
			rb = m_rom_bank;
			if (mp == mapper_mbc1) rb = {(m_mode ? 2'b00 : m_ram_bank), m_rom_bank[4:0]};
			return {1'b0, rb & rom_mask_of(m_rom), a[13]};
		end
		if (mp == mapper_mbc3 && m_rtc) return 9'd0;   // rtc window
		rm = m_ram_bank;
		if ((mp == mapper_mbc1 && !m_mode) || mp == mapper_mbc2) rm = 2'b00;
		return {7'b1000000, rm & ((m_ram == 8'd1 || m_ram == 8'd2) ? 2'b00 : 2'b11)};
	endfunction

	function automatic logic [7:0] exp_do(input logic [15:0] a);
		logic [7:0] sel;
		sel = a[0] ? mem_dout[15:8] : mem_dout[7:0];   // byte picked by the address
		if (a[15:13] == 3'd5 && !m_ram_en) return 8'hff;
		if (mapper_of(m_type) == mapper_mbc2 && a[15:13] == 3'd5 && a[12:9] == 4'd0)
			return 8'hf0 | {4'h0, sel[3:0]};   // nibble ram reads with the top bits set
		return sel;
	endfunction

	task automatic regs_reset();
		m_rom_bank = 7'd1;
		m_ram_bank = 2'd0;
		m_mode     = 1'b0;
		m_rtc      = 1'b0;
		m_ram_en   = 1'b0;
	endtask

	// --------------------
	always @(posedge clk_sys) begin
		if (reset) begin
			m_type = 8'd0;
			m_rom = 8'd0;
			m_ram = 8'd0;
			regs_reset();
			seen_ce = 1'b0;
			busy = 1'b0;
			prev_wait = 1'b0;
			m_ready = 1'b0;
		end else begin
			if (!seen_ce) begin   // quiet window right after reset
				compare("dl_wait", dl_wait, 0);
				compare("mem_we", mem_we, 0);
			end
			if (ce_cpu) seen_ce = 1'b1;

			if (dl_active) begin
				regs_reset();
				if (busy) begin
					lat++;
					if (mem_we) begin
						we_cnt++;
						compare("mem_addr", mem_addr, exp_dl_addr);
						compare("mem_din", mem_din, exp_dl_data);
						compare("mem_ds", mem_ds, 2'b11);
					end
					if (prev_wait && !dl_wait) begin   // handshake done
						compare("mem_we cycles", we_cnt, 8);
						if (lat > 18) fail("dl_wait released too late");
						busy = 1'b0;
						m_ready = 1'b1;
					end
				end else if (mem_we) begin
					fail("mem_we during download with no write pending");
				end
				if (dl_wr) begin
					busy = 1'b1;
					lat = 0;
					we_cnt = 0;
					exp_dl_addr = dl_addr[24:1];
					exp_dl_data = dl_data;
					if (dl_addr == 25'h146) m_type = dl_data[15:8];
					if (dl_addr == 25'h148) begin
						m_ram = dl_data[15:8];
						m_rom = dl_data[7:0];
					end
				end
			end else begin
				if (!m_ready) compare("cpu_do", cpu_do, 8'h00);   // nothing loaded yet
				if (m_ready && (cpu_rd || cpu_wr)) begin
					if (!cpu_addr[15] || cpu_addr[15:13] == 3'd5)
						compare("mem_addr", mem_addr, {3'd0, exp_bank(cpu_addr), cpu_addr[12:1]});
					compare("mem_ds", mem_ds, cpu_addr[0] ? 2'b10 : 2'b01);
					compare("mem_oe", mem_oe, cpu_rd);
					compare("mem_we", mem_we, cpu_wr && m_ram_en && cpu_addr[15:13] == 3'd5);
					if (cpu_wr) compare("mem_din", mem_din, {cpu_di, cpu_di});
					if (cpu_rd) compare("cpu_do", cpu_do, exp_do(cpu_addr));
				end
				if (ce_cpu && cpu_wr) begin   // register write lands here
					case (cpu_addr[15:13])
						3'd0: m_ram_en = (cpu_di[3:0] == 4'ha);
						3'd1: m_rom_bank = (mapper_of(m_type) != mapper_mbc5 && cpu_di[4:0] == 5'd0)
							? 7'd1 : cpu_di[6:0];
						3'd2: begin
							if (mapper_of(m_type) == mapper_mbc3 && cpu_di[3]) begin
								m_rtc = 1'b1;
							end else begin
								m_rtc = 1'b0;
								m_ram_bank = cpu_di[1:0];
							end
						end
						3'd3: if (mapper_of(m_type) == mapper_mbc1) m_mode = cpu_di[0];
						default: ;
					endcase
				end
			end
			compare("cart_ready", cart_ready, m_ready);
			prev_wait = dl_wait;
		end
	end

endmodule

`default_nettype wire

/* verif/cart_chk.sv */
// cartridge protocol checks
// concurrent assertions on the download handshake and the memory request port
`timescale 1ns/1ps
`default_nettype none

module cart_chk (
	input wire       clk_sys,
	input wire       reset,
	input wire       dl_active,
	input wire       dl_wr,
	input wire       dl_wait,
	input wire       ce_cpu,
	input wire       mem_we,
	input wire       mem_oe
);

	int fails = 0;   // failed assertions so far

	// --------------------
	// download handshake
	a_wait_rise: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wr |=> dl_wait)
		else begin fails++; $error("dl_wait did not rise after dl_wr"); end

	a_wait_cause: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(dl_wait) |-> $past(dl_wr))   // only a strobe raises the wait
		else begin fails++; $error("dl_wait rose with no dl_wr before it"); end

	a_ce_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		ce_cpu |=> !ce_cpu ##7 ce_cpu)   // one-cycle pulse every 8 clocks
		else begin fails++; $error("ce_cpu pulse width or period wrong"); end

	// --------------------
	// request port
	a_dl_we_window: assert property (@(posedge clk_sys) disable iff (reset)
		(dl_active && mem_we) |-> dl_wait)
		else begin fails++; $error("download write outside the dl_wait window"); end

	a_release: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(dl_wait) |-> $past(mem_we))   // write period ends as the host is released
		else begin fails++; $error("dl_wait released without a memory write"); end

	a_we_oe: assert property (@(posedge clk_sys) disable iff (reset)
		!(mem_we && mem_oe))
		else begin fails++; $error("mem_we and mem_oe high together"); end

endmodule

bind cart_top cart_chk u_chk (
	.clk_sys (clk_sys), .reset (reset), .dl_active (dl_active), .dl_wr (dl_wr),
	.dl_wait (dl_wait), .ce_cpu (ce_cpu), .mem_we (mem_we), .mem_oe (mem_oe)
);

`default_nettype wire

/* hw/cart_top.sv */
// cartridge top level
// ties clock enable, header capture, MBC registers, bank mapping and the memory port
`timescale 1ns/1ps
`default_nettype none

module cart_top
	import cart_pkg::*;
#(
	parameter int CE_DIV_LOG2   = 3,   // cpu runs at clk_sys/8
	parameter int ROM_BASE_BANK = 0    // image offset in 8 KB banks
) (
	input  wire                    clk_sys,
	input  wire                    reset,
	// image download
	input  wire                    dl_active,
	input  wire                    dl_wr,
	input  wire  [mem_addr_w:0]    dl_addr,
	input  wire  [15:0]            dl_data,
	output logic                   dl_wait,
	// cpu cartridge bus
	output logic                   ce_cpu,
	input  wire  [cpu_addr_w-1:0]  cpu_addr,
	input  wire                    cpu_rd,
	input  wire                    cpu_wr,
	input  wire  [7:0]             cpu_di,
	output logic [7:0]             cpu_do,
	// memory request port
	output logic [mem_addr_w-1:0]  mem_addr,
	output logic [15:0]            mem_din,
	output logic [1:0]             mem_ds,
	output logic                   mem_we,
	output logic                   mem_oe,
	input  wire  [15:0]            mem_dout,
	output logic                   cart_ready
);

	mapper_t               mapper;
	logic [rom_bank_w-1:0] rom_mask;
	logic [ram_bank_w-1:0] ram_mask;
	logic [rom_bank_w-1:0] rom_bank;
	logic [ram_bank_w-1:0] ram_bank;
	logic                  mbc1_mode;
	logic                  rtc_sel;
	logic                  ram_enable;
	logic [bank_w-1:0]     bank;

	cpu_clock_enable #(.CE_DIV_LOG2(CE_DIV_LOG2)) u_ce (
		.clk_sys (clk_sys), .reset (reset), .ce_cpu (ce_cpu)
	);

	header_capture u_hdr (
		.clk_sys (clk_sys), .reset (reset),
		.dl_active (dl_active), .dl_wr (dl_wr), .dl_addr (dl_addr), .dl_data (dl_data),
		.mapper (mapper), .rom_mask (rom_mask), .ram_mask (ram_mask)
	);

	mbc_regs u_regs (
		.clk_sys (clk_sys), .reset (reset), .dl_active (dl_active), .ce_cpu (ce_cpu),
		.cpu_wr (cpu_wr), .cpu_addr (cpu_addr), .cpu_di (cpu_di), .mapper (mapper),
		.rom_bank (rom_bank), .ram_bank (ram_bank), .mbc1_mode (mbc1_mode),
		.rtc_sel (rtc_sel), .ram_enable (ram_enable)
	);

	bank_mapper #(.ROM_BASE_BANK(ROM_BASE_BANK)) u_map (
		.cpu_addr (cpu_addr), .mapper (mapper), .rom_bank (rom_bank), .ram_bank (ram_bank),
		.mbc1_mode (mbc1_mode), .rtc_sel (rtc_sel), .rom_mask (rom_mask),
		.ram_mask (ram_mask), .bank (bank)
	);

	mem_port #(.ROM_BASE_BANK(ROM_BASE_BANK)) u_mem (
		.clk_sys (clk_sys), .reset (reset), .ce_cpu (ce_cpu),
		.dl_active (dl_active), .dl_wr (dl_wr), .dl_addr (dl_addr), .dl_data (dl_data),
		.cpu_addr (cpu_addr), .cpu_rd (cpu_rd), .cpu_wr (cpu_wr), .cpu_di (cpu_di),
		.bank (bank), .mapper (mapper), .ram_enable (ram_enable), .mem_dout (mem_dout),
		.dl_wait (dl_wait), .cart_ready (cart_ready),
		.mem_addr (mem_addr), .mem_din (mem_din), .mem_ds (mem_ds),
		.mem_we (mem_we), .mem_oe (mem_oe), .cpu_do (cpu_do)
	);

endmodule

`default_nettype wire

/* hw/mem_port.sv */
// memory port
// download write handshake, request mux between loader and CPU,
// and byte selection of the read word back to the CPU
`timescale 1ns/1ps
`default_nettype none

module mem_port
	import cart_pkg::*;
#(
	parameter int ROM_BASE_BANK = 0
) (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    ce_cpu,
	input  wire                    dl_active,
	input  wire                    dl_wr,
	input  wire  [mem_addr_w:0]    dl_addr,
	input  dl_word_u               dl_data,
	input  wire  [cpu_addr_w-1:0]  cpu_addr,
	input  wire                    cpu_rd,
	input  wire                    cpu_wr,
	input  wire  [7:0]             cpu_di,
	input  wire  [bank_w-1:0]      bank,
	input  mapper_t                mapper,
	input  wire                    ram_enable,
	input  wire  [15:0]            mem_dout,
	output logic                   dl_wait,
	output logic                   cart_ready,
	output logic [mem_addr_w-1:0]  mem_addr,
	output logic [15:0]            mem_din,
	output logic [1:0]             mem_ds,
	output logic                   mem_we,
	output logic                   mem_oe,
	output logic [7:0]             cpu_do
);

	localparam int offs_w = 12;   // word offset inside an 8 KB window
	localparam logic [mem_addr_w-1:0] base_word = mem_addr_w'(ROM_BASE_BANK) << offs_w;

	logic dn_write;   // loader owns the write strobe this cpu period
	logic in_ram;
	logic cpu_ram_wr;
	logic mbc2_nib;

	// --------------------
	// download handshake
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_wait    <= 1'b0;
			dn_write   <= 1'b0;
			cart_ready <= 1'b0;
		end else begin
			if (dl_wr)
				dl_wait <= 1'b1;
			if (ce_cpu) begin
				dn_write <= dl_wait;
				if (dn_write) begin   // one full period written, release the host
					dl_wait    <= 1'b0;
					dn_write   <= 1'b0;
					cart_ready <= 1'b1;
				end
			end
		end
	end

	// --------------------
	// request mux
	assign in_ram     = (cpu_addr[15:13] == region_cart_ram);
	assign cpu_ram_wr = cpu_wr && ram_enable && in_ram;

	assign mem_addr = dl_active ? dl_addr[mem_addr_w:1] + base_word
	                            : mem_addr_w'({bank, cpu_addr[offs_w:1]});
	assign mem_din  = dl_active ? dl_data.raw : {cpu_di, cpu_di};
	assign mem_ds   = dl_active ? 2'b11 : {cpu_addr[0], ~cpu_addr[0]};   // odd byte on lane 1
	assign mem_we   = dl_active ? dn_write : cpu_ram_wr;
	assign mem_oe   = !dl_active && cpu_rd;

	// --------------------
	// read data
	assign mbc2_nib = (mapper == mapper_mbc2) && in_ram && (cpu_addr[12:9] == 4'h0);   // a000-a1ff

	always_comb begin
		if (!cart_ready)
			cpu_do = 8'h00;
		else if (in_ram && !ram_enable)
			cpu_do = 8'hff;   // disabled ram floats high
		else if (mbc2_nib)
			cpu_do = {4'hf, (cpu_addr[0] ? mem_dout[11:8] : mem_dout[3:0])};
		else
			cpu_do = cpu_addr[0] ? mem_dout[15:8] : mem_dout[7:0];
	end

endmodule

`default_nettype wire

/* hw/bank_mapper.sv */
// bank mapper
// turns the CPU address and the MBC state into the bank field of the memory address
// bit bank_w-1 marks cart ram, the low bits pick an 8 KB window
`timescale 1ns/1ps
`default_nettype none

module bank_mapper
	import cart_pkg::*;
#(
	parameter int ROM_BASE_BANK = 0
) (
	input  wire  [cpu_addr_w-1:0]  cpu_addr,
	input  mapper_t                mapper,
	input  wire  [rom_bank_w-1:0]  rom_bank,
	input  wire  [ram_bank_w-1:0]  ram_bank,
	input  wire                    mbc1_mode,
	input  wire                    rtc_sel,
	input  wire  [rom_bank_w-1:0]  rom_mask,
	input  wire  [ram_bank_w-1:0]  ram_mask,
	output logic [bank_w-1:0]      bank
);

	logic [rom_bank_w-1:0] rom_sel;    // rom bank before size masking
	logic [ram_bank_w-1:0] ram_sel;
	logic [rom_bank_w-1:0] rom_eff;
	logic [ram_bank_w-1:0] ram_eff;
	logic [bank_w-1:0]     bank_raw;   // bank before the image offset
	logic [2:0]            region;

	assign region = cpu_addr[15:13];

	// --------------------
	// per-mapper bank selection
	always_comb begin
		rom_sel = rom_bank;
		ram_sel = ram_bank;
		if (mapper == mapper_mbc1) begin
			// mode 0 lends the ram bank bits to the rom bank
			rom_sel = {(mbc1_mode ? {ram_bank_w{1'b0}} : ram_bank),
			           rom_bank[rom_bank_w-ram_bank_w-1:0]};
			ram_sel = mbc1_mode ? ram_bank : {ram_bank_w{1'b0}};
		end else if (mapper == mapper_mbc2) begin
			ram_sel = '0;   // 512x4 ram inside the chip
		end
	end

	// mirror banks beyond the cart size
	assign rom_eff = rom_sel & rom_mask;
	assign ram_eff = ram_sel & ram_mask;

	// --------------------
	// bank field by address region
	always_comb begin
		bank_raw = '0;   // unmapped regions and the rtc window
		if (mapper == mapper_none) begin
			bank_raw = bank_w'(cpu_addr[14:13]);   // 32 KB linear
		end else if (!cpu_addr[15]) begin
			if (!cpu_addr[14])
				bank_raw = bank_w'(cpu_addr[13]);   // fixed rom bank 0
			else
				bank_raw = bank_w'({rom_eff, cpu_addr[13]});
		end else if (region == region_cart_ram && !(mapper == mapper_mbc3 && rtc_sel)) begin
			bank_raw = {1'b1, {(bank_w-ram_bank_w-1){1'b0}}, ram_eff};
		end
	end

	assign bank = bank_raw + bank_w'(ROM_BASE_BANK);

endmodule

`default_nettype wire

/* hw/mbc_regs.sv */
// MBC control registers
// bank select, banking mode, rtc select and ram enable, all written by the CPU
`timescale 1ns/1ps
`default_nettype none

module mbc_regs
	import cart_pkg::*;
(
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    dl_active,   // image loading holds the mapper idle
	input  wire                    ce_cpu,
	input  wire                    cpu_wr,
	input  wire  [cpu_addr_w-1:0]  cpu_addr,
	input  wire  [7:0]             cpu_di,
	input  mapper_t                mapper,
	output logic [rom_bank_w-1:0]  rom_bank,
	output logic [ram_bank_w-1:0]  ram_bank,
	output logic                   mbc1_mode,
	output logic                   rtc_sel,
	output logic                   ram_enable
);

	logic       reg_wr;   // qualified cpu write
	logic [2:0] region;

	assign reg_wr = ce_cpu && cpu_wr;
	assign region = cpu_addr[15:13];

	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			rom_bank   <= rom_bank_w'(1);   // bank 1 sits in the upper window at start
			ram_bank   <= '0;
			mbc1_mode  <= 1'b0;
			rtc_sel    <= 1'b0;
			ram_enable <= 1'b0;
		end else if (reg_wr) begin
			case (region)
				// --------------------
				region_ram_en: begin
					ram_enable <= (cpu_di[3:0] == ram_enable_key);   // any other nibble disables
				end

				// --------------------
				region_rom_bank: begin
					// bank 0 can't be mapped high except on mbc5
					if (mapper != mapper_mbc5 && cpu_di[4:0] == 5'd0)
						rom_bank <= rom_bank_w'(1);
					else
						rom_bank <= cpu_di[rom_bank_w-1:0];
				end

				// --------------------
				region_ram_bank: begin
					if (mapper == mapper_mbc3 && cpu_di[3]) begin
						rtc_sel <= 1'b1;   // rtc register window, bank kept
					end else begin
						rtc_sel  <= 1'b0;
						ram_bank <= cpu_di[ram_bank_w-1:0];
					end
				end

				// --------------------
				region_mode: begin
					if (mapper == mapper_mbc1)
						mbc1_mode <= cpu_di[0];   // 1 selects 4/32 mode
				end

				default: ;   // writes elsewhere don't touch the mapper
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/header_capture.sv */
// cartridge header capture
// grabs the type and size bytes as the image streams in,
// then decodes the mapper kind and the rom/ram bank masks
`timescale 1ns/1ps
`default_nettype none

module header_capture
	import cart_pkg::*;
(
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    dl_active,
	input  wire                    dl_wr,
	input  wire  [mem_addr_w:0]    dl_addr,   // byte address
	input  dl_word_u               dl_data,
	output mapper_t                mapper,
	output logic [rom_bank_w-1:0]  rom_mask,
	output logic [ram_bank_w-1:0]  ram_mask
);

	logic [7:0] type_byte;
	logic [7:0] rom_size;
	logic [7:0] ram_size;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_byte <= 8'h00;
			rom_size  <= 8'h00;
			ram_size  <= 8'h00;
		end else if (dl_active && dl_wr) begin
			if (dl_addr == hdr_type_addr)
				type_byte <= dl_data.bytes.hi;
			if (dl_addr == hdr_size_addr) begin
				ram_size <= dl_data.bytes.hi;
				rom_size <= dl_data.bytes.lo;
			end
		end
	end

	// --------------------
	// mapper class from the type byte
	always_comb begin
		case (type_byte) inside
			[8'd1:8'd3]:   mapper = mapper_mbc1;   // plain, +ram, +ram+battery
			8'd5, 8'd6:    mapper = mapper_mbc2;
			[8'd15:8'd19]: mapper = mapper_mbc3;   // with or without timer
			[8'd25:8'd30]: mapper = mapper_mbc5;   // incl rumble carts
			default:       mapper = mapper_none;   // 32 KB direct
		endcase
	end

	// rom size code n means 2**(n+1) banks of 16 KB
	always_comb begin
		case (rom_size)
			8'h00:   rom_mask = 7'h01;
			8'h01:   rom_mask = 7'h03;
			8'h02:   rom_mask = 7'h07;
			8'h03:   rom_mask = 7'h0f;
			8'h04:   rom_mask = 7'h1f;
			8'h05:   rom_mask = 7'h3f;
			8'h06:   rom_mask = 7'h7f;
			8'h52:   rom_mask = 7'h47;   // 72 banks
			8'h53:   rom_mask = 7'h4f;   // 80 banks
			default: rom_mask = 7'h5f;   // 96 banks
		endcase
	end

	// 2k and 8k carts have a single ram bank
	assign ram_mask = (ram_size == 8'h01 || ram_size == 8'h02) ? '0 : '1;

endmodule

`default_nettype wire

/* hw/cpu_clock_enable.sv */
// CPU clock enable
// free-running divider giving a one-cycle pulse every 2**CE_DIV_LOG2 clocks
`timescale 1ns/1ps
`default_nettype none

module cpu_clock_enable #(
	parameter int CE_DIV_LOG2 = 3
) (
	input  wire  clk_sys,
	input  wire  reset,
	output logic ce_cpu
);

	logic [CE_DIV_LOG2-1:0] div;   // phase within the cpu period

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div    <= '0;
			ce_cpu <= 1'b0;
		end else begin
			div    <= div + 1'b1;
			ce_cpu <= (div == '1);   // pulse as the count wraps to zero
		end
	end

endmodule

`default_nettype wire

/* hw/cart_pkg.sv */
// cartridge package
// shared widths, CPU address regions, header locations and the download word view
`default_nettype none

package cart_pkg;

	// --------------------
	// widths
	localparam int cpu_addr_w = 16;
	localparam int mem_addr_w = 24;   // memory word address
	localparam int bank_w     = 9;    // bits above the 12-bit word offset of an 8 KB window
	localparam int rom_bank_w = 7;
	localparam int ram_bank_w = 2;

	// --------------------
	// cpu_addr[15:13] decode of the cartridge window
	localparam logic [2:0] region_ram_en   = 3'd0;   // 0000-1fff
	localparam logic [2:0] region_rom_bank = 3'd1;   // 2000-3fff
	localparam logic [2:0] region_ram_bank = 3'd2;   // 4000-5fff
	localparam logic [2:0] region_mode     = 3'd3;   // 6000-7fff
	localparam logic [2:0] region_cart_ram = 3'd5;   // a000-bfff

	// header fields in the download stream
	localparam logic [mem_addr_w:0] hdr_type_addr = 'h146;   // type byte in the high half
	localparam logic [mem_addr_w:0] hdr_size_addr = 'h148;   // ram size high, rom size low

	localparam logic [3:0] ram_enable_key = 4'ha;

	typedef enum logic [2:0] {
		mapper_none,
		mapper_mbc1,
		mapper_mbc2,
		mapper_mbc3,
		mapper_mbc5
	} mapper_t;

	// one download word seen whole or as two header bytes
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [7:0] hi;   // mapper type or ram size
			logic [7:0] lo;   // rom size
		} bytes;
	} dl_word_u;

endpackage

`default_nettype wire
